//--- project.f
+incdir+hw
hw/core_pkg.sv
hw/stage_reg.sv
hw/register_file.sv
hw/decoder.sv
hw/alu_execute.sv
hw/core_top.sv
tests/core_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
mkdir -p build

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
  -f project.f --Mdir build -o core_sim > build/compile.log 2>&1 \
  || { cat build/compile.log; echo "verilator build failed"; exit 1; }

./build/core_sim > build/sim.log 2>&1
cat build/sim.log

grep -q "Test failed" build/sim.log && { echo "simulation FAILED"; exit 1; } \
  || { grep -q "Test completed successfully" build/sim.log || exit 1; }

//--- tests/core_stim.txt
// columns: instruction, expected retire_rd, expected retire_data (all hex)
// every source register is written earlier in the list, so the list can repeat
123450B7 01 12345000 // lui  x1, 0x12345
67808093 01 12345678 // addi x1, x1, 0x678
FFF00113 02 FFFFFFFF // addi x2, x0, -1
002081B3 03 12345677 // add  x3, x1, x2
40118233 04 FFFFFFFF // sub  x4, x3, x1
00409293 05 23456780 // slli x5, x1, 4
8002C313 06 DCBA9F80 // xori x6, x5, -2048
40835393 07 FFDCBA9F // srai x7, x6, 8
00735433 08 00000001 // srl  x8, x6, x7
0083A4B3 09 00000001 // slt  x9, x7, x8
0083B533 0A 00000000 // sltu x10, x7, x8
00508013 00 1234567D // addi x0, x1, 5
005065B3 0B 23456780 // or   x11, x0, x5
00002603 00 00000000 // lw   x12, 0(x0), unsupported
0065F633 0C 00000780 // and  x12, x11, x6
002646B3 0D FFFFF87F // xor  x13, x12, x2
00969733 0E FFFFF0FE // sll  x14, x13, x9
00000073 00 00000000 // ecall, unsupported
409757B3 0F FFFFF87F // sra  x15, x14, x9
FFE7A813 10 00000001 // slti x16, x15, -2
7FF06893 11 000007FF // ori  x17, x0, 0x7ff
0F07F913 12 00000070 // andi x18, x15, 0xf0
01C15993 13 0000000F // srli x19, x2, 28
0109BA13 14 00000001 // sltiu x20, x19, 16
00000000 00 00000000 // end of list

//--- tests/core_tb.sv
`default_nettype none

module core_tb;

  import core_pkg::*;

  localparam int MaxLines = 64;
  localparam int ResetCycles = 5;
  localparam int Latency = 3;
  localparam int RandomPasses = 3;
  localparam int PassCycleLimit = 2000;

  logic clock;
  logic reset;
  logic inst_valid;
  inst_t inst;
  logic retire_ready;
  logic inst_ready;
  logic retire_valid;
  reg_addr_t retire_rd;
  word_t retire_data;

  logic [31:0] stim_mem [0:3*MaxLines-1];
  int num_lines;
  logic [31:0] lfsr_state;
  int cycle;

  // stim line and accept cycle of each item in flight
  int pending_line [$];
  int pending_cycle [$];

  core_top u_dut (
    .clock(clock),
    .reset(reset),
    .inst_valid(inst_valid),
    .inst(inst),
    .retire_ready(retire_ready),
    .inst_ready(inst_ready),
    .retire_valid(retire_valid),
    .retire_rd(retire_rd),
    .retire_data(retire_data)
  );

  always #4 clock = ~clock;

  task automatic stop_with_failure();
    $display("Test failed");
    $fatal(1);
  endtask

  function automatic logic [31:0] lfsr_advance(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
      next = next ^ 32'h8020_0003;
    end
    return next;
  endfunction

  // one lfsr step per bit taken
  task automatic random_bits(input int count, output logic [7:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      value = {value[6:0], lfsr_state[0]};
      lfsr_state = lfsr_advance(lfsr_state);
    end
  endtask

  task automatic load_stim();
    $readmemh("tests/core_stim.txt", stim_mem);
    num_lines = 0;
    // a zero instruction ends the list
    while (num_lines < MaxLines && stim_mem[3*num_lines] !== '0
           && !$isunknown(stim_mem[3*num_lines])) begin
      num_lines++;
    end
    assert (num_lines > 0) else begin
      $display("stimulus file holds no instructions");
      stop_with_failure();
    end
  endtask

  task automatic check_retire(input logic check_latency);
    int line;
    int accepted_at;
    logic [31:0] exp_rd;
    logic [31:0] exp_data;
    assert (pending_line.size() > 0) else begin
      $display("retire seen with no instruction in flight");
      stop_with_failure();
    end
    line = pending_line.pop_front();
    accepted_at = pending_cycle.pop_front();
    exp_rd = stim_mem[3*line+1];
    exp_data = stim_mem[3*line+2];
    assert (32'(retire_rd) == exp_rd) else begin
      $display("MISMATCH retire_rd line %0d: got %h expected %h", line, retire_rd, exp_rd);
      stop_with_failure();
    end
    assert (retire_data == exp_data) else begin
      $display("MISMATCH retire_data line %0d: got %h expected %h", line, retire_data, exp_data);
      stop_with_failure();
    end
    if (check_latency) begin
      assert (cycle - accepted_at == Latency) else begin
        $display("line %0d retired %0d cycles after issue instead of %0d",
                 line, cycle - accepted_at, Latency);
        stop_with_failure();
      end
    end
  endtask

  // issue the whole list and collect every retire
  task automatic run_pass(input logic random_mode);
    int next_line;
    int retired;
    int cycles;
    int in_flight;
    logic accepted;
    logic gap;
    logic [7:0] draw;
    next_line = 0;
    retired = 0;
    cycles = 0;
    accepted = 1'b0;
    while (retired < num_lines) begin
      @(negedge clock);
      retire_ready = 1'b1;
      gap = 1'b0;
      if (random_mode) begin
        random_bits(2, draw);
        retire_ready = (draw[1:0] != 2'b00);
        random_bits(2, draw);
        gap = (draw[1:0] == 2'b11);
      end
      // a held instruction stays on the port until taken
      if (!inst_valid || accepted) begin
        inst_valid = 1'b0;
        if (next_line < num_lines && !gap) begin
          inst_valid = 1'b1;
          inst = stim_mem[3*next_line];
        end
      end
      #1;
      cycle++;
      cycles++;
      in_flight = pending_line.size();
      assert (inst_ready || in_flight == 3) else begin
        $display("inst_ready low with only %0d items in flight", in_flight);
        stop_with_failure();
      end
      accepted = inst_valid && inst_ready;
      if (accepted) begin
        pending_line.push_back(next_line);
        pending_cycle.push_back(cycle);
        next_line++;
      end
      if (retire_valid && retire_ready) begin
        check_retire(!random_mode);
        retired++;
      end
      assert (cycles < PassCycleLimit) else begin
        $display("timeout after %0d cycles with %0d of %0d retired",
                 cycles, retired, num_lines);
        stop_with_failure();
      end
    end
  endtask

  initial begin
    clock = 1'b0;
    reset = 1'b1;
    inst_valid = 1'b0;
    inst = '0;
    retire_ready = 1'b0;
    lfsr_state = 32'h53f3_de5c;
    cycle = 0;
    load_stim();

    repeat (ResetCycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    retire_ready = 1'b1;
    #1;
    assert (!retire_valid && inst_ready) else begin
      $display("after reset retire_valid=%b inst_ready=%b", retire_valid, inst_ready);
      stop_with_failure();
    end

    // full rate first, latency checked on every item
    run_pass(1'b0);
    for (int p = 0; p < RandomPasses; p++) begin
      run_pass(1'b1);
    end

    repeat (4) begin
      @(negedge clock);
      retire_ready = 1'b1;
      #1;
      assert (!retire_valid) else begin
        $display("extra retire after the last instruction");
        stop_with_failure();
      end
    end

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- hw/core_top.sv
`default_nettype none

module core_top (
  input wire logic clock,
  input wire logic reset,
  input wire logic inst_valid,
  input core_pkg::inst_t inst,
  input wire logic retire_ready,
  output logic inst_ready,
  output logic retire_valid,
  output core_pkg::reg_addr_t retire_rd,
  output core_pkg::word_t retire_data
);

  import core_pkg::*;

  logic dec_valid;
  inst_t dec_inst;
  logic ex_in_ready;
  logic ex_valid;
  logic wb_in_ready;
  ex_payload_t dec_payload;
  ex_payload_t ex_payload;
  wb_payload_t ex_wb_payload;
  wb_payload_t wb_payload;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t rs1_data;
  word_t rs2_data;
  word_t ex_result;

  stage_reg #(.payload_t(inst_t)) u_decode_reg (
    .clock(clock),
    .reset(reset),
    .in_valid(inst_valid),
    .in_payload(inst),
    .out_ready(ex_in_ready),
    .in_ready(inst_ready),
    .out_valid(dec_valid),
    .out_payload(dec_inst)
  );

  // register values are captured as the item leaves decode
  decoder u_decoder (
    .inst(dec_inst),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .rd(dec_payload.rd),
    .alu_op(dec_payload.alu_op),
    .op1(dec_payload.op1),
    .op2(dec_payload.op2),
    .use_rs1(dec_payload.use_rs1),
    .use_rs2(dec_payload.use_rs2)
  );

  assign dec_payload.rs1 = rs1_addr;
  assign dec_payload.rs2 = rs2_addr;

  // the retire handshake is the register write
  register_file u_register_file (
    .clock(clock),
    .reset(reset),
    .rs1_addr(rs1_addr),
    .rs2_addr(rs2_addr),
    .write_enable(retire_valid && retire_ready),
    .write_addr(wb_payload.rd),
    .write_data(wb_payload.result),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data)
  );

  stage_reg #(.payload_t(ex_payload_t)) u_execute_reg (
    .clock(clock),
    .reset(reset),
    .in_valid(dec_valid),
    .in_payload(dec_payload),
    .out_ready(wb_in_ready),
    .in_ready(ex_in_ready),
    .out_valid(ex_valid),
    .out_payload(ex_payload)
  );

  alu_execute u_alu_execute (
    .alu_op(ex_payload.alu_op),
    .rs1(ex_payload.rs1),
    .rs2(ex_payload.rs2),
    .op1(ex_payload.op1),
    .op2(ex_payload.op2),
    .use_rs1(ex_payload.use_rs1),
    .use_rs2(ex_payload.use_rs2),
    .wb_valid(retire_valid),
    .wb_rd(wb_payload.rd),
    .wb_result(wb_payload.result),
    .result(ex_result)
  );

  assign ex_wb_payload.rd = ex_payload.rd;
  assign ex_wb_payload.result = ex_result;

  stage_reg #(.payload_t(wb_payload_t)) u_writeback_reg (
    .clock(clock),
    .reset(reset),
    .in_valid(ex_valid),
    .in_payload(ex_wb_payload),
    .out_ready(retire_ready),
    .in_ready(wb_in_ready),
    .out_valid(retire_valid),
    .out_payload(wb_payload)
  );

  assign retire_rd = wb_payload.rd;
  assign retire_data = wb_payload.result;

endmodule

`default_nettype wire

//--- hw/alu_execute.sv
`default_nettype none

`include "core_macros.svh"

module alu_execute (
  input core_pkg::alu_op_e alu_op,
  input core_pkg::reg_addr_t rs1,
  input core_pkg::reg_addr_t rs2,
  input core_pkg::word_t op1,
  input core_pkg::word_t op2,
  input wire logic use_rs1,
  input wire logic use_rs2,
  input wire logic wb_valid,
  input core_pkg::reg_addr_t wb_rd,
  input core_pkg::word_t wb_result,
  output core_pkg::word_t result
);

  import core_pkg::*;

  logic wb_writes;
  logic fwd1;
  logic fwd2;
  word_t a;
  word_t b;
  logic [4:0] shamt;

  // writeback holds the newest value of its rd
  assign wb_writes = wb_valid && (wb_rd != '0);
  assign fwd1 = wb_writes && use_rs1 && (wb_rd == rs1);
  assign fwd2 = wb_writes && use_rs2 && (wb_rd == rs2);

  assign a = fwd1 ? wb_result : op1;
  assign b = fwd2 ? wb_result : op2;
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      alu_add: begin
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_sll: begin
        result = a << shamt;
      end
      alu_slt: begin
        result = {{(`CORE_XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      end
      alu_sltu: begin
        result = {{(`CORE_XLEN-1){1'b0}}, (a < b)};
      end
      alu_xor: begin
        result = a ^ b;
      end
      alu_srl: begin
        result = a >> shamt;
      end
      alu_sra: begin
        result = word_t'($signed(a) >>> shamt);
      end
      alu_or: begin
        result = a | b;
      end
      alu_and: begin
        result = a & b;
      end
      default: begin
        // lui
        result = b;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/decoder.sv
`default_nettype none

`include "core_macros.svh"

module decoder (
  input core_pkg::inst_t inst,
  input core_pkg::word_t rs1_data,
  input core_pkg::word_t rs2_data,
  output core_pkg::reg_addr_t rs1_addr,
  output core_pkg::reg_addr_t rs2_addr,
  output core_pkg::reg_addr_t rd,
  output core_pkg::alu_op_e alu_op,
  output core_pkg::word_t op1,
  output core_pkg::word_t op2,
  output logic use_rs1,
  output logic use_rs2
);

  import core_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t imm_i;
  word_t imm_u;
  alu_op_e base_op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];
  assign rs1_addr = inst[19:15];
  assign rs2_addr = inst[24:20];

  assign imm_i = {{(`CORE_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_u = {inst[31:12], 12'b0};

  // funct3 map shared by reg-reg and reg-imm forms
  always_comb begin
    case (funct3)
      3'b000: base_op = alu_add;
      3'b001: base_op = alu_sll;
      3'b010: base_op = alu_slt;
      3'b011: base_op = alu_sltu;
      3'b100: base_op = alu_xor;
      3'b101: base_op = funct7[5] ? alu_sra : alu_srl;
      3'b110: base_op = alu_or;
      default: base_op = alu_and;
    endcase
  end

  always_comb begin
    alu_op = alu_add;
    op1 = rs1_data;
    op2 = rs2_data;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    rd = inst[11:7];
    case (opcode)
      `CORE_OPC_OP: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        // sub only exists in the reg-reg form
        alu_op = (funct3 == 3'b000 && funct7[5]) ? alu_sub : base_op;
      end
      `CORE_OPC_OP_IMM: begin
        use_rs1 = 1'b1;
        op2 = imm_i;
        alu_op = base_op;
      end
      `CORE_OPC_LUI: begin
        op1 = '0;
        op2 = imm_u;
        alu_op = alu_pass2;
      end
      default: begin
        // retires without a register write
        rd = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- hw/register_file.sv
`default_nettype none

`include "core_macros.svh"

module register_file (
  input wire logic clock,
  input wire logic reset,
  input core_pkg::reg_addr_t rs1_addr,
  input core_pkg::reg_addr_t rs2_addr,
  input wire logic write_enable,
  input core_pkg::reg_addr_t write_addr,
  input core_pkg::word_t write_data,
  output core_pkg::word_t rs1_data,
  output core_pkg::word_t rs2_data
);

  import core_pkg::*;

  localparam int Entries = 1 << `CORE_REG_ADDR_W;

  // x0 has no storage
  word_t regs [1:Entries-1];

  logic write_live;

  assign write_live = write_enable && (write_addr != '0);

  // write-through so a same-cycle retire is seen by decode
  function automatic word_t read_port(input reg_addr_t addr);
    word_t value;
    if (addr == '0) begin
      value = '0;
    end else if (write_live && (write_addr == addr)) begin
      value = write_data;
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  assign rs1_data = read_port(rs1_addr);
  assign rs2_data = read_port(rs2_addr);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 1; i < Entries; i++) begin
        regs[i] <= '0;
      end
    end else if (write_live) begin
      regs[write_addr] <= write_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/stage_reg.sv
`default_nettype none

module stage_reg #(
  parameter type payload_t = logic
) (
  input wire logic clock,
  input wire logic reset,
  input wire logic in_valid,
  input payload_t in_payload,
  input wire logic out_ready,
  output logic in_ready,
  output logic out_valid,
  output payload_t out_payload
);

  // allowin: empty, or the held item leaves this cycle
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      out_payload <= in_payload;
    end
  end

endmodule

`default_nettype wire

//--- hw/core_pkg.sv
`default_nettype none

`include "core_macros.svh"

package core_pkg;

  typedef logic [`CORE_XLEN-1:0] word_t;
  typedef logic [`CORE_REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`CORE_INST_W-1:0] inst_t;

  // pass2 carries the U immediate for lui
  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass2
  } alu_op_e;

  // decode to execute
  typedef struct packed {
    alu_op_e alu_op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    word_t op1;
    word_t op2;
    logic use_rs1;
    logic use_rs2;
  } ex_payload_t;

  // execute to writeback
  typedef struct packed {
    reg_addr_t rd;
    word_t result;
  } wb_payload_t;

endpackage

`default_nettype wire

//--- hw/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// datapath width
`define CORE_XLEN 32

// register index width, 32 architectural registers
`define CORE_REG_ADDR_W 5

`define CORE_INST_W 32

// major opcodes, inst[6:0]
`define CORE_OPC_OP 7'b0110011
`define CORE_OPC_OP_IMM 7'b0010011
`define CORE_OPC_LUI 7'b0110111

`endif
